// ==== all.f ====
hw/rv32i_types.sv
hw/cacheline_adapter.sv
hw/icache.sv
hw/inst_queue.sv
hw/fetch_ctrl.sv
hw/cpu_frontend.sv
bench/bmem_model.sv
bench/cpu_frontend_tb.sv

// ==== bench/bmem_model.sv ====
`timescale 1ns/10ps

module bmem_model
import rv32i_types::*;
#(
    parameter int MAX_GAP = 5   // idle cycles allowed between beats
) (
    input  logic  clk,
    input  logic  rst,

    input  addr_t bmem_addr_i,
    input  logic  bmem_read_i,
    output logic  bmem_ready_o,
    output beat_t bmem_rdata_o,
    output logic  bmem_rvalid_o
);

    logic  rst_seen;
    logic  read_seen;
    addr_t addr_seen;
    logic  busy;
    addr_t base_addr;
    int    beat_idx;
    int    gap;

    // low half is the address, high half scrambled
    function automatic word_t mem_word(input addr_t a);
        return {a[15:0] ^ 16'h5a5a, a[15:0]};
    endfunction

    function automatic beat_t mem_beat(input addr_t a);
        return {mem_word(a + 32'd4), mem_word(a)};
    endfunction

    initial begin
        bmem_ready_o  = 1'b0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
        busy          = 1'b0;
        beat_idx      = 0;
        gap           = 0;
    end

    always begin
        @(negedge clk);
        rst_seen  = rst;            // mid cycle, everything settled
        read_seen = bmem_read_i;
        addr_seen = bmem_addr_i;
        @(posedge clk);
        #1;
        bmem_rvalid_o = 1'b0;
        if (rst_seen) begin
            busy         = 1'b0;
            bmem_ready_o = 1'b0;
        end else begin
            if (read_seen) begin
                busy      = 1'b1;
                base_addr = addr_seen;
                beat_idx  = 0;
                gap       = $urandom_range(MAX_GAP, 0);
            end else if (busy) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    bmem_rvalid_o = 1'b1;
                    bmem_rdata_o  = mem_beat(base_addr + 32'(8 * beat_idx));
                    beat_idx++;
                    gap = $urandom_range(MAX_GAP, 0);
                    if (beat_idx == BEATS_PER_LINE) busy = 1'b0;
                end
            end
            bmem_ready_o = !busy && ($urandom_range(1, 0) == 1);  // no new burst while busy
        end
    end

endmodule : bmem_model

// ==== bench/cpu_frontend_tb.sv ====
`timescale 1ns/10ps

module cpu_frontend_tb
import rv32i_types::*;
();

    localparam int SEED          = 21562;
    localparam int CLK_HALF      = 50;
    localparam int RESET_CYCLES  = 5;
    localparam int MAX_BEAT_GAP  = 5;
    localparam int NUM_INSTS     = 400;
    localparam int STALL_CYCLES  = 60;
    localparam int FIRST_STALL   = 100;
    localparam int STALL_SPACING = 150;
    localparam int WAIT_LIMIT    = 300;     // cycles with an empty queue
    localparam int RUN_LIMIT     = 20000;

    logic  clk;
    logic  rst;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_ready;
    beat_t bmem_rdata;
    logic  bmem_rvalid;
    logic  inst_valid_o;
    addr_t pc_o;
    word_t inst_o;
    logic  dequeue_i;

    addr_t exp_pc;
    addr_t exp_line_addr = RESET_PC;
    int    deq_count     = 0;
    int    line_reads    = 0;
    int    stall_left;
    int    next_stall;
    int    wait_cycles;
    int    cycles;

    cpu_frontend UUT (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .inst_valid_o  (inst_valid_o),
        .pc_o          (pc_o),
        .inst_o        (inst_o),
        .dequeue_i     (dequeue_i)
    );

    bmem_model #(.MAX_GAP(MAX_BEAT_GAP)) bmem (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    function automatic word_t expected_inst(input addr_t a);
        return {a[15:0] ^ 16'h5a5a, a[15:0]};
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_error($sformatf("Fail %s: expected %h, actual %h",
                                  test_name, expected, actual));
    endtask

    task automatic check_quiet();
        assert (bmem_read == 1'b0)
            else report_mismatch("reset_state bmem_read", 0, bmem_read);
        assert (inst_valid_o == 1'b0)
            else report_mismatch("reset_state inst_valid", 0, inst_valid_o);
    endtask

    task automatic pop_and_check();
        assert (pc_o == exp_pc) else report_mismatch("program_order", exp_pc, pc_o);
        assert (inst_o == expected_inst(exp_pc))
            else report_mismatch("instruction_data", expected_inst(exp_pc), inst_o);
        dequeue_i = 1'b1;
        exp_pc    = exp_pc + 32'd4;
        deq_count++;
    endtask

    // every line read goes out in order, once
    always @(negedge clk) begin
        if (!rst && bmem_read) begin
            assert (bmem_addr[4:0] == 5'd0)
                else report_mismatch("line_alignment", 32'd0, 32'(bmem_addr[4:0]));
            assert (bmem_addr == exp_line_addr)
                else report_mismatch("line_sequence", exp_line_addr, bmem_addr);
            exp_line_addr = exp_line_addr + 32'd32;
            line_reads++;
            // requested pc sits at most 14 entries past the dequeued ones
            assert ((line_reads - 1) * 8 <= deq_count + IQUEUE_DEPTH - 2)
                else stop_with_error("memory read issued while the queue was full");
        end
    end

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        dequeue_i   = 1'b0;
        exp_pc      = RESET_PC;
        stall_left  = 0;
        next_stall  = FIRST_STALL;
        wait_cycles = 0;
        cycles      = 0;

        // last check lands in the first cycle out of reset
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            #1;
            if (c == RESET_CYCLES - 1) rst = 1'b0;
            @(negedge clk);
            check_quiet();
        end

        while (deq_count < NUM_INSTS) begin
            @(posedge clk);
            #1;
            dequeue_i = 1'b0;
            cycles++;
            if (cycles > RUN_LIMIT) begin
                stop_with_error("run did not reach the instruction count in time");
            end
            if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) begin
                    assert (inst_valid_o)
                        else stop_with_error("queue empty after a stall window");
                end
            end else if (deq_count == next_stall) begin
                stall_left = STALL_CYCLES;      // queue fills up meanwhile
                next_stall = next_stall + STALL_SPACING;
            end else if (inst_valid_o) begin
                wait_cycles = 0;
                if ($urandom_range(1, 0) == 1) pop_and_check();
            end else begin
                wait_cycles++;
                if (wait_cycles > WAIT_LIMIT) begin
                    stop_with_error("timed out waiting for an instruction");
                end
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule : cpu_frontend_tb

// ==== hw/cacheline_adapter.sv ====
`timescale 1ns/10ps

module cacheline_adapter
import rv32i_types::*;
(
    input  logic  clk,
    input  logic  rst,

    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i,

    output line_t line_data_o,
    output logic  line_valid_o
);

    localparam logic [1:0] LAST_BEAT = 2'(BEATS_PER_LINE - 1);

    logic [1:0] beat_cnt;
    line_t      line_q;
    logic       line_valid_q;

    // beat count and the done pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= bmem_rvalid_i && (beat_cnt == LAST_BEAT);
            if (bmem_rvalid_i) begin
                beat_cnt <= (beat_cnt == LAST_BEAT) ? '0 : beat_cnt + 2'd1;
            end
        end
    end

    // lowest beat lands in the lowest slot
    // line stays put until the next burst starts
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q[beat_cnt * $bits(beat_t) +: $bits(beat_t)] <= bmem_rdata_i;
        end
    end

    assign line_data_o  = line_q;
    assign line_valid_o = line_valid_q;

    line_valid_single_pulse : assert property (
        @(posedge clk) disable iff (rst) line_valid_o |=> !line_valid_o
    ) else $error("line_valid_o held for more than one cycle");

endmodule : cacheline_adapter

// ==== hw/cpu_frontend.sv ====
`timescale 1ns/10ps

module cpu_frontend
import rv32i_types::*;
(
    input  logic  clk,
    input  logic  rst,

    // burst memory port
    output addr_t bmem_addr_o,
    output logic  bmem_read_o,
    input  logic  bmem_ready_i,
    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i,

    // to rename
    output logic  inst_valid_o,
    output addr_t pc_o,
    output word_t inst_o,
    input  logic  dequeue_i
);

    logic         fetch_req;
    addr_t        fetch_addr;
    logic         fetch_resp;
    word_t        fetch_data;

    line_t        line_data;
    logic         line_valid;

    logic         enq;
    fetch_entry_t enq_data;
    fetch_entry_t head_entry;
    logic         q_full;
    logic         q_empty;

    fetch_ctrl fetch_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .q_full_i     (q_full),
        .fetch_resp_i (fetch_resp),
        .fetch_data_i (fetch_data),
        .fetch_req_o  (fetch_req),
        .fetch_addr_o (fetch_addr),
        .enq_o        (enq),
        .enq_data_o   (enq_data)
    );

    icache icache_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_req_i  (fetch_req),
        .fetch_addr_i (fetch_addr),
        .fetch_data_o (fetch_data),
        .fetch_resp_o (fetch_resp),
        .bmem_ready_i (bmem_ready_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .line_data_i  (line_data),
        .line_valid_i (line_valid)
    );

    cacheline_adapter cacheline_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_data_o   (line_data),
        .line_valid_o  (line_valid)
    );

    inst_queue #(.WIDTH(64), .DEPTH(IQUEUE_DEPTH)) inst_queue_i (
        .clk        (clk),
        .rst        (rst),
        .enq_i      (enq),
        .enq_data_i (enq_data),
        .deq_i      (dequeue_i),
        .deq_data_o (head_entry),
        .full_o     (q_full),
        .empty_o    (q_empty)
    );

    assign inst_valid_o = !q_empty;
    assign pc_o         = head_entry[63:32];
    assign inst_o       = head_entry[31:0];

endmodule : cpu_frontend

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/10ps

module fetch_ctrl
import rv32i_types::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         q_full_i,

    // cache side
    input  logic         fetch_resp_i,
    input  word_t        fetch_data_i,
    output logic         fetch_req_o,
    output addr_t        fetch_addr_o,

    // queue side
    output logic         enq_o,
    output fetch_entry_t enq_data_o
);

    addr_t pc_q;
    logic  outstanding_q;   // request sent, no response yet
    logic  run_q;           // low for the reset cycles

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= RESET_PC;
            outstanding_q <= 1'b0;
            run_q         <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (fetch_req_o) begin
                outstanding_q <= 1'b1;
            end else if (fetch_resp_i) begin
                outstanding_q <= 1'b0;
                pc_q          <= pc_q + 32'd4;  // no branches yet
            end
        end
    end

    // q_full already counts the entry just enqueued
    assign fetch_req_o  = run_q && !outstanding_q && !q_full_i;
    assign fetch_addr_o = pc_q;

    assign enq_o      = fetch_resp_i;
    assign enq_data_o = {pc_q, fetch_data_i};

    // cache must not answer without a request
    resp_only_when_outstanding : assert property (
        @(posedge clk) disable iff (rst) fetch_resp_i |-> outstanding_q
    ) else $error("fetch response with no request pending");

endmodule : fetch_ctrl

// ==== hw/icache.sv ====
`timescale 1ns/10ps

module icache
import rv32i_types::*;
(
    input  logic  clk,
    input  logic  rst,

    // fetch side
    input  logic  fetch_req_i,
    input  addr_t fetch_addr_i,
    output word_t fetch_data_o,
    output logic  fetch_resp_o,

    // memory side
    input  logic  bmem_ready_i,
    output addr_t bmem_addr_o,
    output logic  bmem_read_o,
    input  line_t line_data_i,
    input  logic  line_valid_i
);

    typedef enum logic [1:0] {
        IDLE,
        MISS_REQ,
        MISS_WAIT,
        FILL
    } icache_state_t;

    icache_state_t state;

    logic [ICACHE_SETS-1:0] valid_q;
    logic [TAG_W-1:0]       tags_q  [ICACHE_SETS];
    line_t                  lines_q [ICACHE_SETS];

    addr_t req_addr_q;      // address of the miss being served
    word_t data_q;
    logic  resp_q;

    // lookup on the incoming address
    logic [ICACHE_INDEX_W-1:0] lookup_idx;
    logic [TAG_W-1:0]          lookup_tag;
    logic [2:0]                lookup_word;
    line_t                     lookup_line;
    logic                      hit;

    // fill on the latched address
    logic [ICACHE_INDEX_W-1:0] fill_idx;
    logic [TAG_W-1:0]          fill_tag;
    logic [2:0]                fill_word;

    assign lookup_idx  = fetch_addr_i[OFFSET_W +: ICACHE_INDEX_W];
    assign lookup_tag  = fetch_addr_i[31 -: TAG_W];
    assign lookup_word = fetch_addr_i[OFFSET_W-1:2];
    assign lookup_line = lines_q[lookup_idx];
    assign hit         = valid_q[lookup_idx] && (tags_q[lookup_idx] == lookup_tag);

    assign fill_idx  = req_addr_q[OFFSET_W +: ICACHE_INDEX_W];
    assign fill_tag  = req_addr_q[31 -: TAG_W];
    assign fill_word = req_addr_q[OFFSET_W-1:2];

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            resp_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            resp_q <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (fetch_req_i) begin
                        if (hit) begin
                            resp_q <= 1'b1;
                        end else begin
                            state <= MISS_REQ;
                        end
                    end
                end
                MISS_REQ: begin
                    if (bmem_ready_i) state <= MISS_WAIT;   // read goes out this cycle
                end
                MISS_WAIT: begin
                    if (line_valid_i) state <= FILL;
                end
                FILL: begin
                    valid_q[fill_idx] <= 1'b1;
                    resp_q            <= 1'b1;
                    state             <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if ((state == IDLE) && fetch_req_i) begin
            req_addr_q <= fetch_addr_i;
            data_q     <= lookup_line[lookup_word * $bits(word_t) +: $bits(word_t)];
        end
        if (state == FILL) begin
            // adapter still holds the line here
            tags_q[fill_idx]  <= fill_tag;
            lines_q[fill_idx] <= line_data_i;
            data_q <= line_data_i[fill_word * $bits(word_t) +: $bits(word_t)];
        end
    end

    assign bmem_addr_o  = {req_addr_q[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign bmem_read_o  = (state == MISS_REQ) && bmem_ready_i;
    assign fetch_data_o = data_q;
    assign fetch_resp_o = resp_q;

    // fetch_ctrl keeps a single request in flight
    req_only_in_idle : assert property (
        @(posedge clk) disable iff (rst) fetch_req_i |-> (state == IDLE)
    ) else $error("fetch request while cache busy");

    // adapter only completes a line we asked for
    line_only_in_wait : assert property (
        @(posedge clk) disable iff (rst) line_valid_i |-> (state == MISS_WAIT)
    ) else $error("unexpected line from adapter");

endmodule : icache

// ==== hw/inst_queue.sv ====
`timescale 1ns/10ps

module inst_queue #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 16    // power of two
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             enq_i,
    input  logic [WIDTH-1:0] enq_data_i,
    input  logic             deq_i,
    output logic [WIDTH-1:0] deq_data_o,

    output logic             full_o,
    output logic             empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [WIDTH-1:0] mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) wr_ptr <= wr_ptr + 1'b1;
            if (deq_i) rd_ptr <= rd_ptr + 1'b1;
            unique case ({enq_i, deq_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i) mem_q[wr_ptr] <= enq_data_i;
    end

    assign deq_data_o = mem_q[rd_ptr];

    // one slot spare for the fetch in flight
    assign full_o  = (count >= CNT_W'(DEPTH - 1));
    assign empty_o = (count == '0);

    no_overflow : assert property (
        @(posedge clk) disable iff (rst) enq_i |-> (count != CNT_W'(DEPTH))
    ) else $error("enqueue into full queue");

    no_underflow : assert property (
        @(posedge clk) disable iff (rst) deq_i |-> !empty_o
    ) else $error("dequeue from empty queue");

endmodule : inst_queue

// ==== hw/rv32i_types.sv ====
package rv32i_types;

    // basic widths
    typedef logic [31:0]  addr_t;   // byte address
    typedef logic [31:0]  word_t;   // one instruction
    typedef logic [63:0]  beat_t;   // one memory beat
    typedef logic [255:0] line_t;   // one cache line

    // queue entry, pc on top and instruction below
    typedef logic [63:0]  fetch_entry_t;

    // first fetch after reset
    localparam addr_t RESET_PC = 32'h1eceb000;

    // memory burst shape
    localparam int BEATS_PER_LINE = 4;

    // icache geometry
    localparam int ICACHE_SETS    = 16;
    localparam int ICACHE_INDEX_W = 4;
    localparam int OFFSET_W       = 5;   // 32 byte lines
    localparam int TAG_W          = 23;  // 32 - index - offset

    // instruction queue
    localparam int IQUEUE_DEPTH   = 16;

endpackage : rv32i_types
